//--- hw/rvc_defs.svh
`ifndef RVC_DEFS_SVH
`define RVC_DEFS_SVH

// Flow control depths
`define RVC_IN_DEPTH    2
`define RVC_OUT_CREDITS 2

// Base opcodes used by the expansions
`define RVC_OP_IMM 7'b0010011
`define RVC_OP     7'b0110011
`define RVC_LUI    7'b0110111
`define RVC_JAL    7'b1101111
`define RVC_JALR   7'b1100111
`define RVC_BRANCH 7'b1100011
`define RVC_LOAD   7'b0000011
`define RVC_STORE  7'b0100011

// Funct3 codes
`define RVC_F3_ADD 3'b000
`define RVC_F3_SLL 3'b001
`define RVC_F3_SR  3'b101
`define RVC_F3_XOR 3'b100
`define RVC_F3_OR  3'b110
`define RVC_F3_AND 3'b111
`define RVC_F3_BEQ 3'b000
`define RVC_F3_BNE 3'b001
// Word width for loads and stores
`define RVC_F3_W   3'b010

// Fixed instruction words
`define RVC_NOP    32'h0000_0013
`define RVC_EBREAK 32'h0010_0073

`endif

//--- hw/rvc_egress.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_egress (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 head_valid,
  input  rvc_pkg::parcel_t     head_parcel,
  input  rvc_pkg::expansion_t  q0,
  input  rvc_pkg::expansion_t  q1,
  input  rvc_pkg::expansion_t  q2,
  output logic                 pop,
  output logic                 out_valid,
  output rvc_pkg::rvc_result_t out_result,
  input  logic                 out_credit
);

  localparam int CNT_W = $clog2(`RVC_OUT_CREDITS + 1);

  rvc_pkg::quadrant_t   quadrant;
  rvc_pkg::rvc_result_t sel;
  // Downstream credits held
  logic [CNT_W-1:0]     credit_cnt;

  assign quadrant = head_parcel[1:0];

  // Decoder pick by quadrant
  always_comb begin
    sel.compressed = 1'b1;
    case (quadrant)
      2'b00: begin
        sel.instr   = q0.instr;
        sel.illegal = q0.illegal;
      end
      2'b01: begin
        sel.instr   = q1.instr;
        sel.illegal = q1.illegal;
      end
      2'b10: begin
        sel.instr   = q2.instr;
        sel.illegal = q2.illegal;
      end
      // 32-bit parcel passes as NOP
      default: begin
        sel.instr      = `RVC_NOP;
        sel.illegal    = 1'b0;
        sel.compressed = 1'b0;
      end
    endcase
  end

  // Take the head whenever a credit is held
  assign pop = head_valid && (credit_cnt != '0);

  // Result register
  always_ff @(posedge clk) begin
    if (pop) begin
      out_result <= sel;
    end
  end

  // Valid pulse and credit accounting
  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid  <= 1'b0;
      credit_cnt <= CNT_W'(`RVC_OUT_CREDITS);
    end else begin
      out_valid <= pop;
      case ({pop, out_credit})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- hw/rvc_expander_top.sv
`default_nettype none

module rvc_expander_top (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 in_valid,
  input  rvc_pkg::parcel_t     in_parcel,
  output logic                 in_credit,
  output logic                 out_valid,
  output rvc_pkg::rvc_result_t out_result,
  input  logic                 out_credit
);

  // Buffer head towards the decoders
  logic                head_valid;
  rvc_pkg::parcel_t    head_parcel;
  logic                pop;

  // One expansion per quadrant
  rvc_pkg::expansion_t q0_exp;
  rvc_pkg::expansion_t q1_exp;
  rvc_pkg::expansion_t q2_exp;

  // ====================================================================
  // Input buffer
  // ====================================================================

  rvc_ingress u_ingress (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_parcel   (in_parcel),
    .in_credit   (in_credit),
    .head_valid  (head_valid),
    .head_parcel (head_parcel),
    .pop         (pop)
  );

  // Decoders all look at the same head parcel
  rvc_quadrant0 u_q0 (
    .parcel    (head_parcel),
    .expansion (q0_exp)
  );

  rvc_quadrant1 u_q1 (
    .parcel    (head_parcel),
    .expansion (q1_exp)
  );

  rvc_quadrant2 u_q2 (
    .parcel    (head_parcel),
    .expansion (q2_exp)
  );

  // ====================================================================
  // Output register and downstream credits
  // ====================================================================

  rvc_egress u_egress (
    .clk         (clk),
    .reset       (reset),
    .head_valid  (head_valid),
    .head_parcel (head_parcel),
    .q0          (q0_exp),
    .q1          (q1_exp),
    .q2          (q2_exp),
    .pop         (pop),
    .out_valid   (out_valid),
    .out_result  (out_result),
    .out_credit  (out_credit)
  );

endmodule

`default_nettype wire

//--- hw/rvc_ingress.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_ingress (
  input  logic             clk,
  input  logic             reset,
  input  logic             in_valid,
  input  rvc_pkg::parcel_t in_parcel,
  output logic             in_credit,
  output logic             head_valid,
  output rvc_pkg::parcel_t head_parcel,
  input  logic             pop
);

  localparam int PTR_W = $clog2(`RVC_IN_DEPTH);
  localparam int CNT_W = $clog2(`RVC_IN_DEPTH + 1);

  // Parcel storage
  rvc_pkg::parcel_t mem [`RVC_IN_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // Upstream only sends on a held credit, so a slot is always free
  logic push;
  assign push = in_valid;

  // Oldest entry drives the decoders
  assign head_valid  = (count != '0);
  assign head_parcel = mem[rd_ptr];

  // Storage write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_parcel;
    end
  end

  // Pointers, occupancy and credit return
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(`RVC_IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(`RVC_IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // One credit back per freed slot
      in_credit <= pop;
    end
  end

endmodule

`default_nettype wire

//--- hw/rvc_pkg.sv
`default_nettype none

`include "rvc_defs.svh"

package rvc_pkg;

  // ====================================================================
  // Vector types
  // ====================================================================

  // One compressed parcel
  typedef logic [15:0] parcel_t;

  // Expanded base instruction
  typedef logic [31:0] instr_t;

  // Full register number x0 to x31
  typedef logic [4:0] reg_idx_t;

  // Compressed register number, x8 to x15
  typedef logic [2:0] creg_idx_t;

  // Low two parcel bits
  typedef logic [1:0] quadrant_t;

  // ====================================================================
  // Bundles
  // ====================================================================

  // Output of one quadrant decoder
  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } expansion_t;

  // Item delivered downstream
  typedef struct packed {
    instr_t instr;
    logic   illegal;
    logic   compressed;
  } rvc_result_t;

endpackage

`default_nettype wire

//--- hw/rvc_quadrant0.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_quadrant0 (
  input  rvc_pkg::parcel_t    parcel,
  output rvc_pkg::expansion_t expansion
);

  localparam rvc_pkg::reg_idx_t REG_SP = 5'd2;

  // Compressed register fields
  rvc_pkg::creg_idx_t creg_lo;
  rvc_pkg::creg_idx_t creg_hi;
  // Mapped onto x8 to x15
  rvc_pkg::reg_idx_t  reg_lo;
  rvc_pkg::reg_idx_t  reg_hi;

  // Scrambled immediates, already scaled
  logic [9:0] imm_addi4spn;
  logic [6:0] imm_word;

  assign creg_lo = parcel[4:2];
  assign creg_hi = parcel[9:7];
  assign reg_lo  = {2'b01, creg_lo};
  assign reg_hi  = {2'b01, creg_hi};

  // nzuimm[5:4|9:6|2|3] in bits 12:5
  assign imm_addi4spn = {parcel[10:7], parcel[12:11], parcel[5], parcel[6], 2'b00};
  // offset[5:3] in 12:10, offset[2|6] in 6:5
  assign imm_word = {parcel[5], parcel[12:10], parcel[6], 2'b00};

  always_comb begin
    expansion.instr   = `RVC_NOP;
    expansion.illegal = 1'b0;
    case (parcel[15:13])
      // C.ADDI4SPN as ADDI rd', sp, nzuimm
      3'b000: begin
        if (imm_addi4spn == '0) begin
          expansion.illegal = 1'b1;
        end else begin
          expansion.instr = {2'b00, imm_addi4spn, REG_SP, `RVC_F3_ADD, reg_lo, `RVC_OP_IMM};
        end
      end
      // C.LW
      3'b010: expansion.instr = {5'b0, imm_word, reg_hi, `RVC_F3_W, reg_lo, `RVC_LOAD};
      // C.SW, store immediate split around rs2
      3'b110: begin
        expansion.instr = {5'b0, imm_word[6:5], reg_lo, reg_hi, `RVC_F3_W,
                           imm_word[4:0], `RVC_STORE};
      end
      // Float, double and reserved slots
      default: expansion.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rvc_quadrant1.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_quadrant1 (
  input  rvc_pkg::parcel_t    parcel,
  output rvc_pkg::expansion_t expansion
);

  localparam rvc_pkg::reg_idx_t REG_ZERO = 5'd0;
  localparam rvc_pkg::reg_idx_t REG_RA   = 5'd1;
  localparam rvc_pkg::reg_idx_t REG_SP   = 5'd2;

  // Full register field in bits 11:7
  rvc_pkg::reg_idx_t  rd;
  // Compressed fields, rd'/rs1' and rs2'
  rvc_pkg::creg_idx_t creg_hi;
  rvc_pkg::creg_idx_t creg_lo;
  rvc_pkg::reg_idx_t  reg_hi;
  rvc_pkg::reg_idx_t  reg_lo;

  logic [11:0] imm6;
  logic [11:0] imm_addi16sp;
  logic [19:0] imm_lui;
  logic [20:0] off_j;
  logic [12:0] off_b;

  assign rd      = parcel[11:7];
  assign creg_hi = parcel[9:7];
  assign creg_lo = parcel[4:2];
  assign reg_hi  = {2'b01, creg_hi};
  assign reg_lo  = {2'b01, creg_lo};

  // ====================================================================
  // Immediate reassembly
  // ====================================================================

  // Signed 6-bit imm of C.ADDI, C.LI, C.ANDI and shifts
  assign imm6 = {{7{parcel[12]}}, parcel[6:2]};
  // nzimm[9|4|6|8:7|5], scaled by 16
  assign imm_addi16sp = {{3{parcel[12]}}, parcel[4:3], parcel[5], parcel[2], parcel[6], 4'b0000};
  // Upper immediate bits 31:12
  assign imm_lui = {{15{parcel[12]}}, parcel[6:2]};
  // offset[11|4|9:8|10|6|7|3:1|5]
  assign off_j = {{9{parcel[12]}}, parcel[12], parcel[8], parcel[10:9], parcel[6],
                  parcel[7], parcel[2], parcel[11], parcel[5:3], 1'b0};
  // offset[8|4:3] and offset[7:6|2:1|5]
  assign off_b = {{4{parcel[12]}}, parcel[12], parcel[6:5], parcel[2], parcel[11:10],
                  parcel[4:3], 1'b0};

  // ====================================================================
  // Expansion
  // ====================================================================

  always_comb begin
    expansion.instr   = `RVC_NOP;
    expansion.illegal = 1'b0;
    case (parcel[15:13])
      // C.NOP and C.ADDI, rd x0 with nonzero imm is reserved
      3'b000: begin
        if (rd == REG_ZERO && imm6 != '0) begin
          expansion.illegal = 1'b1;
        end else begin
          expansion.instr = {imm6, rd, `RVC_F3_ADD, rd, `RVC_OP_IMM};
        end
      end
      // C.JAL links through ra
      3'b001: begin
        expansion.instr = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], REG_RA, `RVC_JAL};
      end
      // C.LI, rd x0 kept as hint
      3'b010: expansion.instr = {imm6, REG_ZERO, `RVC_F3_ADD, rd, `RVC_OP_IMM};
      // C.ADDI16SP or C.LUI
      3'b011: begin
        if (rd == REG_ZERO) begin
          expansion.illegal = 1'b1;
        end else if (rd == REG_SP) begin
          if (imm_addi16sp == '0) begin
            expansion.illegal = 1'b1;
          end else begin
            expansion.instr = {imm_addi16sp, REG_SP, `RVC_F3_ADD, REG_SP, `RVC_OP_IMM};
          end
        end else if (imm_lui == '0) begin
          expansion.illegal = 1'b1;
        end else begin
          expansion.instr = {imm_lui, rd, `RVC_LUI};
        end
      end
      // Shifts, C.ANDI and register-register ops on rd'
      3'b100: begin
        case (parcel[11:10])
          2'b00, 2'b01: begin
            // Shift amount bit 5 has no RV32 meaning
            if (parcel[12]) begin
              expansion.illegal = 1'b1;
            end else begin
              expansion.instr = {1'b0, parcel[10], 5'b0, parcel[6:2], reg_hi,
                                 `RVC_F3_SR, reg_hi, `RVC_OP_IMM};
            end
          end
          2'b10: expansion.instr = {imm6, reg_hi, `RVC_F3_AND, reg_hi, `RVC_OP_IMM};
          default: begin
            case ({parcel[12], parcel[6:5]})
              3'b000: expansion.instr = {7'b0100000, reg_lo, reg_hi, `RVC_F3_ADD, reg_hi, `RVC_OP};
              3'b001: expansion.instr = {7'b0000000, reg_lo, reg_hi, `RVC_F3_XOR, reg_hi, `RVC_OP};
              3'b010: expansion.instr = {7'b0000000, reg_lo, reg_hi, `RVC_F3_OR, reg_hi, `RVC_OP};
              3'b011: expansion.instr = {7'b0000000, reg_lo, reg_hi, `RVC_F3_AND, reg_hi, `RVC_OP};
              // SUBW, ADDW and reserved
              default: expansion.illegal = 1'b1;
            endcase
          end
        endcase
      end
      // C.J
      3'b101: begin
        expansion.instr = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], REG_ZERO, `RVC_JAL};
      end
      // C.BEQZ and C.BNEZ compare rs1' with x0
      default: begin
        expansion.instr = {off_b[12], off_b[10:5], REG_ZERO, reg_hi,
                           parcel[13] ? `RVC_F3_BNE : `RVC_F3_BEQ,
                           off_b[4:1], off_b[11], `RVC_BRANCH};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/rvc_quadrant2.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_quadrant2 (
  input  rvc_pkg::parcel_t    parcel,
  output rvc_pkg::expansion_t expansion
);

  localparam rvc_pkg::reg_idx_t REG_ZERO = 5'd0;
  localparam rvc_pkg::reg_idx_t REG_RA   = 5'd1;
  localparam rvc_pkg::reg_idx_t REG_SP   = 5'd2;

  // rd and rs1 share bits 11:7
  rvc_pkg::reg_idx_t rd;
  rvc_pkg::reg_idx_t rs2;

  // Stack offsets, word scaled
  logic [7:0] imm_lwsp;
  logic [7:0] imm_swsp;

  assign rd  = parcel[11:7];
  assign rs2 = parcel[6:2];

  // uimm[5] in 12, uimm[4:2|7:6] in 6:2
  assign imm_lwsp = {parcel[3:2], parcel[12], parcel[6:4], 2'b00};
  // uimm[5:2|7:6] in 12:7
  assign imm_swsp = {parcel[8:7], parcel[12:9], 2'b00};

  always_comb begin
    expansion.instr   = `RVC_NOP;
    expansion.illegal = 1'b0;
    case (parcel[15:13])
      // C.SLLI, rd x0 and zero shift kept as hints
      3'b000: begin
        if (parcel[12]) begin
          expansion.illegal = 1'b1;
        end else begin
          expansion.instr = {7'b0, parcel[6:2], rd, `RVC_F3_SLL, rd, `RVC_OP_IMM};
        end
      end
      // C.LWSP needs a destination
      3'b010: begin
        if (rd == REG_ZERO) begin
          expansion.illegal = 1'b1;
        end else begin
          expansion.instr = {4'b0, imm_lwsp, REG_SP, `RVC_F3_W, rd, `RVC_LOAD};
        end
      end
      // ==================================================================
      // Jump, move, add and breakpoint group
      // ==================================================================
      3'b100: begin
        if (!parcel[12]) begin
          if (rs2 != REG_ZERO) begin
            // C.MV as ADDI rd, rs2, 0
            expansion.instr = {12'b0, rs2, `RVC_F3_ADD, rd, `RVC_OP_IMM};
          end else if (rd == REG_ZERO) begin
            // C.JR without a target register
            expansion.illegal = 1'b1;
          end else begin
            expansion.instr = {12'b0, rd, `RVC_F3_ADD, REG_ZERO, `RVC_JALR};
          end
        end else if (rs2 != REG_ZERO) begin
          // C.ADD
          expansion.instr = {7'b0, rs2, rd, `RVC_F3_ADD, rd, `RVC_OP};
        end else if (rd == REG_ZERO) begin
          expansion.instr = `RVC_EBREAK;
        end else begin
          // C.JALR links through ra
          expansion.instr = {12'b0, rd, `RVC_F3_ADD, REG_RA, `RVC_JALR};
        end
      end
      // C.SWSP, store immediate split around rs2
      3'b110: begin
        expansion.instr = {4'b0, imm_swsp[7:5], rs2, REG_SP, `RVC_F3_W,
                           imm_swsp[4:0], `RVC_STORE};
      end
      // FLDSP, FSDSP, FLWSP, FSWSP and unused
      default: expansion.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hw
hw/rvc_pkg.sv
hw/rvc_ingress.sv
hw/rvc_quadrant0.sv
hw/rvc_quadrant1.sv
hw/rvc_quadrant2.sv
hw/rvc_egress.sv
hw/rvc_expander_top.sv
verification/rvc_expander_props.sv
verification/tb_rvc_expander.sv

//--- verification/rvc_expander_props.sv
`default_nettype none

`include "rvc_defs.svh"

module rvc_expander_props (
  input logic                               clk,
  input logic                               reset,
  input logic                               in_valid,
  input logic                               out_valid,
  input logic                               out_credit,
  input logic [$clog2(`RVC_IN_DEPTH+1)-1:0] fifo_count
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failed assertions, summed into the closing report
  int assert_fails;
  // Downstream credits the DUT holds, seen only from its ports
  int credits_held;

  always_ff @(posedge clk) begin
    if (reset) begin
      credits_held <= `RVC_OUT_CREDITS;
    end else begin
      credits_held <= credits_held - int'(out_valid) + int'(out_credit);
    end
  end

  // ====================================================================
  // Reset
  // ====================================================================

  // Output flop cleared once reset has been seen for an edge
  a_reset_quiet: assert property (
    @(posedge clk) reset ##1 reset |-> !out_valid
  ) else begin
    $error("out_valid high while reset is held");
    assert_fails++;
  end

  // ====================================================================
  // Credit loops
  // ====================================================================

  // Upstream never pushes into a full buffer
  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset)
    in_valid |-> fifo_count < `RVC_IN_DEPTH
  ) else begin
    $error("in_valid while the input buffer is full");
    assert_fails++;
  end

  // Each output item spends a credit that downstream handed back
  a_credit_held: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> credits_held > 0
  ) else begin
    $error("out_valid with no downstream credit");
    assert_fails++;
  end

endmodule

bind rvc_expander_top rvc_expander_props u_props (
  .clk        (clk),
  .reset      (reset),
  .in_valid   (in_valid),
  .out_valid  (out_valid),
  .out_credit (out_credit),
  .fifo_count (u_ingress.count)
);

`default_nettype wire

//--- verification/tb_rvc_expander.sv
`default_nettype none

`include "rvc_defs.svh"

module tb_rvc_expander;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int RANDOM_FULL    = 2000;
  localparam int RANDOM_BP      = 800;
  // Item flag expectations
  localparam int FLAG_LEGAL   = 0;
  localparam int FLAG_ILLEGAL = 1;
  localparam int FLAG_ANY     = 2;

  logic                 clk;
  logic                 reset;
  logic                 in_valid;
  rvc_pkg::parcel_t     in_parcel;
  logic                 in_credit;
  logic                 out_valid;
  rvc_pkg::rvc_result_t out_result;
  logic                 out_credit;

  // Scoreboard state
  rvc_pkg::parcel_t sent_q [$];
  int               flag_q [$];
  int               sent;
  int               delivered;
  int               up_returned;
  int               down_pending;
  int               down_returned;
  int               hold_left;
  int               value_errors;
  int               flow_errors;
  int               cycles;
  logic             bp_mode;
  logic [31:0]      seed;
  logic [31:0]      seed_bp;

  rvc_expander_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (in_valid),
    .in_parcel  (in_parcel),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_credit (out_credit)
  );

  always #10 clk = ~clk;

  // ====================================================================
  // Instruction encoders and sign extension
  // ====================================================================

  function automatic logic [31:0] sext(input logic [31:0] v, input int bits);
    logic [31:0] mask;
    mask = 32'hFFFF_FFFF << bits;
    return v[bits-1] ? (v | mask) : (v & ~mask);
  endfunction

  function automatic logic [31:0] enc_i(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [31:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, `RVC_F3_W, imm[4:0], `RVC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [31:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd0, rs1, f3, imm[4:1], imm[11], `RVC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RVC_JAL};
  endfunction

  // ====================================================================
  // Reference expansion
  // ====================================================================

  function automatic rvc_pkg::rvc_result_t expand_ref(input rvc_pkg::parcel_t p);
    rvc_pkg::rvc_result_t r;
    logic [4:0]  rd;
    logic [4:0]  rs2;
    logic [4:0]  rdp;
    logic [4:0]  rs2p;
    logic [31:0] imm;
    r.instr      = `RVC_NOP;
    r.illegal    = 1'b0;
    r.compressed = 1'b1;
    rd   = p[11:7];
    rs2  = p[6:2];
    rdp  = {2'b01, p[9:7]};
    rs2p = {2'b01, p[4:2]};
    imm  = sext({26'd0, p[12], p[6:2]}, 6);
    case ({p[1:0], p[15:13]})
      // Quadrant 0
      5'b00_000: begin
        imm = (p[10:7] << 6) | (p[12:11] << 4) | (p[5] << 3) | (p[6] << 2);
        if (imm == 0) r.illegal = 1'b1;
        else r.instr = enc_i(imm, 5'd2, `RVC_F3_ADD, rs2p, `RVC_OP_IMM);
      end
      5'b00_010: begin
        imm = (p[5] << 6) | (p[12:10] << 3) | (p[6] << 2);
        r.instr = enc_i(imm, rdp, `RVC_F3_W, rs2p, `RVC_LOAD);
      end
      5'b00_110: begin
        imm = (p[5] << 6) | (p[12:10] << 3) | (p[6] << 2);
        r.instr = enc_s(imm, rs2p, rdp);
      end
      // Quadrant 1
      5'b01_000: begin
        if (rd == 0 && imm != 0) r.illegal = 1'b1;
        else r.instr = enc_i(imm, rd, `RVC_F3_ADD, rd, `RVC_OP_IMM);
      end
      5'b01_001, 5'b01_101: begin
        imm = sext({20'd0, p[12], p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0}, 12);
        r.instr = enc_j(imm, p[15] ? 5'd0 : 5'd1);
      end
      5'b01_010: r.instr = enc_i(imm, 5'd0, `RVC_F3_ADD, rd, `RVC_OP_IMM);
      5'b01_011: begin
        if (rd == 0) begin
          r.illegal = 1'b1;
        end else if (rd == 2) begin
          imm = sext({22'd0, p[12], p[4:3], p[5], p[2], p[6], 4'd0}, 10);
          if (imm == 0) r.illegal = 1'b1;
          else r.instr = enc_i(imm, 5'd2, `RVC_F3_ADD, 5'd2, `RVC_OP_IMM);
        end else if (imm == 0) begin
          r.illegal = 1'b1;
        end else begin
          r.instr = {imm[19:0], rd, `RVC_LUI};
        end
      end
      5'b01_100: begin
        if (p[11:10] == 2'b10) begin
          r.instr = enc_i(imm, rdp, `RVC_F3_AND, rdp, `RVC_OP_IMM);
        end else if (p[12]) begin
          // Shift bit 5 and the word forms
          r.illegal = 1'b1;
        end else if (p[11] == 1'b0) begin
          r.instr = enc_r(p[10] ? 7'h20 : 7'h00, rs2, rdp, `RVC_F3_SR, rdp, `RVC_OP_IMM);
        end else begin
          case (p[6:5])
            2'b00:   r.instr = enc_r(7'h20, rs2p, rdp, `RVC_F3_ADD, rdp, `RVC_OP);
            2'b01:   r.instr = enc_r(7'h00, rs2p, rdp, `RVC_F3_XOR, rdp, `RVC_OP);
            2'b10:   r.instr = enc_r(7'h00, rs2p, rdp, `RVC_F3_OR, rdp, `RVC_OP);
            default: r.instr = enc_r(7'h00, rs2p, rdp, `RVC_F3_AND, rdp, `RVC_OP);
          endcase
        end
      end
      5'b01_110, 5'b01_111: begin
        imm = sext({23'd0, p[12], p[6:5], p[2], p[11:10], p[4:3], 1'b0}, 9);
        r.instr = enc_b(imm, rdp, p[13] ? `RVC_F3_BNE : `RVC_F3_BEQ);
      end
      // Quadrant 2
      5'b10_000: begin
        if (p[12]) r.illegal = 1'b1;
        else r.instr = enc_r(7'h00, rs2, rd, `RVC_F3_SLL, rd, `RVC_OP_IMM);
      end
      5'b10_010: begin
        imm = (p[3:2] << 6) | (p[12] << 5) | (p[6:4] << 2);
        if (rd == 0) r.illegal = 1'b1;
        else r.instr = enc_i(imm, 5'd2, `RVC_F3_W, rd, `RVC_LOAD);
      end
      5'b10_100: begin
        if (rs2 != 0) begin
          r.instr = p[12] ? enc_r(7'h00, rs2, rd, `RVC_F3_ADD, rd, `RVC_OP)
                          : enc_i(0, rs2, `RVC_F3_ADD, rd, `RVC_OP_IMM);
        end else if (rd == 0) begin
          if (p[12]) r.instr = `RVC_EBREAK;
          else r.illegal = 1'b1;
        end else begin
          r.instr = enc_i(0, rd, `RVC_F3_ADD, p[12] ? 5'd1 : 5'd0, `RVC_JALR);
        end
      end
      5'b10_110: begin
        imm = (p[8:7] << 6) | (p[12:9] << 2);
        r.instr = enc_s(imm, rs2, 5'd2);
      end
      default: begin
        // 32-bit parcel or an unused slot
        if (p[1:0] == 2'b11) r.compressed = 1'b0;
        else r.illegal = 1'b1;
      end
    endcase
    return r;
  endfunction

  // ====================================================================
  // Upstream side
  // ====================================================================

  // One clock, counting returned upstream credits
  task automatic next_cycle();
    @(negedge clk);
    if (in_credit) up_returned++;
  endtask

  task automatic send_parcel(input rvc_pkg::parcel_t p, input int flag);
    next_cycle();
    while (sent - up_returned >= `RVC_IN_DEPTH) begin
      in_valid = 1'b0;
      next_cycle();
    end
    in_valid  = 1'b1;
    in_parcel = p;
    sent_q.push_back(p);
    flag_q.push_back(flag);
    sent++;
  endtask

  // Idle until every sent parcel has come out and its credit is back
  task automatic drain();
    next_cycle();
    in_valid = 1'b0;
    while (delivered != sent || up_returned != sent) begin
      next_cycle();
    end
  endtask

  // ====================================================================
  // Compare and downstream credit process
  // ====================================================================

  always @(negedge clk) begin
    rvc_pkg::rvc_result_t exp;
    rvc_pkg::parcel_t     p;
    int                   flag;
    if (!reset && out_valid) begin
      if (sent_q.size() == 0) begin
        $display("Output arrived with no parcel outstanding at time %0t", $time);
        flow_errors++;
      end else begin
        p    = sent_q.pop_front();
        flag = flag_q.pop_front();
        exp  = expand_ref(p);
        delivered++;
        down_pending++;
        if (out_result !== exp) begin
          $display("Error at %0t: parcel %h gave %h/%b/%b, expected %h/%b/%b", $time, p,
                   out_result.instr, out_result.illegal, out_result.compressed,
                   exp.instr, exp.illegal, exp.compressed);
          value_errors++;
        end
        if (flag != FLAG_ANY && out_result.illegal !== (flag == FLAG_ILLEGAL)) begin
          $display("Error at %0t: parcel %h illegal flag %b", $time, p, out_result.illegal);
          value_errors++;
        end
      end
      if (delivered > `RVC_OUT_CREDITS + down_returned) begin
        $display("More outputs than downstream credits at time %0t", $time);
        flow_errors++;
      end
    end
    // Credit return for items taken
    out_credit = 1'b0;
    if (hold_left > 0) begin
      hold_left--;
    end else if (down_pending > 0) begin
      out_credit = 1'b1;
      down_pending--;
      down_returned++;
      if (bp_mode && ($random(seed_bp) & 3) == 0) hold_left = $random(seed_bp) & 15;
    end
  end

  // Watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles, outputs missing (%0d of %0d)",
               cycles, delivered, sent);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================

  initial begin
    rvc_pkg::parcel_t legal_list [$];
    rvc_pkg::parcel_t bad_list [$];
    rvc_pkg::parcel_t wide_list [$];
    clk = 1'b0;
    reset = 1'b1;
    in_valid = 1'b0;
    in_parcel = '0;
    out_credit = 1'b0;
    sent = 0;
    delivered = 0;
    up_returned = 0;
    down_pending = 0;
    down_returned = 0;
    hold_left = 0;
    value_errors = 0;
    flow_errors = 0;
    cycles = 0;
    bp_mode = 1'b0;
    seed = 32'he2a9;
    seed_bp = 32'he2a9 ^ 32'h5a5a;
    repeat (4) @(negedge clk);
    reset = 1'b0;

    // Quiet after reset
    repeat (3) begin
      next_cycle();
      if (out_valid || in_credit) begin
        $display("Output or credit active before any parcel at time %0t", $time);
        flow_errors++;
      end
    end

    // Quadrant 0, quadrant 1 with hints, quadrant 2 with hints and EBREAK
    legal_list = '{16'h0040, 16'h4188, 16'hC188,
                   16'h0001, 16'h0505, 16'h0501, 16'h3FFD, 16'h4505, 16'h4005,
                   16'h6141, 16'h6505, 16'h8005, 16'h8405, 16'h8805, 16'h8C05,
                   16'h8C25, 16'h8C45, 16'h8C65, 16'hA001, 16'hBFFD, 16'hC001,
                   16'hE001, 16'hFC7D,
                   16'h0506, 16'h0006, 16'h4502, 16'hC02A, 16'h8082, 16'h852A,
                   16'h9002, 16'h9502, 16'h952A};
    foreach (legal_list[i]) send_parcel(legal_list[i], FLAG_LEGAL);

    // Zero immediates, missing registers, shift bit 5, RV64 and float slots
    bad_list = '{16'h0000, 16'h6501, 16'h6101, 16'h6001, 16'h0005, 16'h4002,
                 16'h8002, 16'h9005, 16'h9405, 16'h1006, 16'h9C01, 16'h9C21,
                 16'h2000, 16'h6000, 16'h8000, 16'hA000, 16'hE000, 16'h2002,
                 16'h6002, 16'hA002, 16'hE002};
    foreach (bad_list[i]) send_parcel(bad_list[i], FLAG_ILLEGAL);

    wide_list = '{16'h0003, 16'hFFFF, 16'h1233, 16'h8067};
    foreach (wide_list[i]) send_parcel(wide_list[i], FLAG_LEGAL);
    drain();

    // Full rate random parcels
    repeat (RANDOM_FULL) send_parcel(rvc_pkg::parcel_t'($random(seed)), FLAG_ANY);
    drain();

    // Random stretches without downstream credit
    bp_mode = 1'b1;
    repeat (RANDOM_BP) send_parcel(rvc_pkg::parcel_t'($random(seed)), FLAG_ANY);
    drain();
    bp_mode = 1'b0;
    repeat (4) next_cycle();

    if (up_returned != delivered || delivered != sent) begin
      $display("Credit pulses %0d, delivered %0d, sent %0d do not agree",
               up_returned, delivered, sent);
      flow_errors++;
    end

    $display("Value errors: %0d, flow errors: %0d, assertion errors: %0d, items: %0d",
             value_errors, flow_errors, u_dut.u_props.assert_fails, delivered);
    if (value_errors == 0 && flow_errors == 0 && u_dut.u_props.assert_fails == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
